/* sim.f */
hw/rvIsaPkg.sv
hw/memBusPkg.sv
hw/alu.sv
hw/regFile.sv
hw/instDecoder.sv
hw/coreSequencer.sv
hw/coreTop.sv
sim/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module coreTb -o coreTbSim

out=$(./obj_dir/coreTbSim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

/* sim/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb;

   localparam memBusPkg::addrT startPc = '0;
   localparam int maxLat = 4;

   logic            clk = 1'b0;
   logic            rstn;
   logic            launch;
   logic            memReq;
   memBusPkg::addrT memAddr;
   logic            memWe;
   memBusPkg::dataT memWData;
   logic            memRspValid;
   memBusPkg::dataT memRData;
   logic            halt;

   // add sub xor or and slt sltu sll srl sra
   localparam logic [2:0] aluF3 [10] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3, 3'd1,
                                         3'd5, 3'd5};
   localparam logic [6:0] aluF7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20};

   rvIsaPkg::wordT  prog [$];
   memBusPkg::dataT mem [256];      // word-indexed memory
   rvIsaPkg::wordT  refRegs [32];
   memBusPkg::dataT refMem [256];
   memBusPkg::addrT refPc = startPc;
   logic            refHalted = 1'b0;
   logic            dataPending = 1'b0;
   logic            pendWe;
   logic [4:0]      pendRd;
   memBusPkg::addrT pendAddr;
   memBusPkg::dataT pendData;
   logic [31:0]     rngState = 32'hc67b_c285;
   logic            busy = 1'b0;
   int              waitCnt;
   int              cycles = 0;
   int              timeoutLimit;

   always #50 clk = ~clk;

   coreTop #(.bootAddr(startPc)) u_dut (
      .clk         (clk),
      .rstn        (rstn),
      .memReq      (memReq),
      .memAddr     (memAddr),
      .memWe       (memWe),
      .memWData    (memWData),
      .memRspValid (memRspValid),
      .memRData    (memRData),
      .launch      (launch),
      .halt        (halt)
   );

   function automatic logic [31:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic logic [4:0] randomReg(); // x1..x6
      return 5'(nextRand() % 32'd6 + 32'd1);
   endfunction

   function automatic rvIsaPkg::wordT encR(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rvIsaPkg::opOp};
   endfunction

   function automatic rvIsaPkg::wordT encI(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic rvIsaPkg::wordT encS(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, rvIsaPkg::f3Sw, imm[4:0], rvIsaPkg::opStore};
   endfunction

   function automatic rvIsaPkg::wordT encU(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   // steps the ISA one access ahead and returns the expected access
   function automatic void refNext(output logic expWe, output memBusPkg::addrT expAddr,
                                   output memBusPkg::dataT expData);
      rvIsaPkg::wordT ins;
      rvIsaPkg::wordT a;
      rvIsaPkg::wordT b;
      rvIsaPkg::wordT res;
      logic [6:0]     op;
      logic [6:0]     f7;
      logic [2:0]     f3;
      logic [4:0]     rd;
      logic           known;
      expWe   = pendWe;
      expAddr = pendAddr;
      expData = pendData;
      if (dataPending) begin
         dataPending = 1'b0;
         if (pendWe) begin
            refMem[pendAddr[7:0]] = pendData;
         end else if (pendRd != 5'd0) begin
            refRegs[pendRd] = refMem[pendAddr[7:0]];
         end
      end else begin
         ins     = refMem[refPc[7:0]];
         expWe   = 1'b0;
         expAddr = refPc;
         expData = '0;
         refPc   = refPc + 32'd1;
         op      = ins[6:0];
         f3      = ins[14:12];
         f7      = ins[31:25];
         rd      = ins[11:7];
         a       = refRegs[ins[19:15]];
         b       = (op == rvIsaPkg::opOp) ? refRegs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
         res     = '0;
         known   = 1'b1;
         case (op)
            rvIsaPkg::opOp, rvIsaPkg::opOpImm: begin
               if (op == rvIsaPkg::opOp) begin
                  known = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
               end else begin
                  known = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 ||
                          (f3 == 3'd5 && f7 == 7'h20);
               end
               case (f3)
                  3'd0: res = (op == rvIsaPkg::opOp && f7 == 7'h20) ? a - b : a + b;
                  3'd1: res = a << b[4:0];
                  3'd2: res = {31'b0, $signed(a) < $signed(b)};
                  3'd3: res = {31'b0, a < b};
                  3'd4: res = a ^ b;
                  3'd5: begin
                     if (f7 == 7'h20) begin
                        res = $signed(a) >>> b[4:0];
                     end else begin
                        res = a >> b[4:0];
                     end
                  end
                  3'd6: res = a | b;
                  default: res = a & b;
               endcase
            end
            rvIsaPkg::opLui:   res = {ins[31:12], 12'b0};
            rvIsaPkg::opAuipc: res = expAddr + {ins[31:12], 12'b0};
            rvIsaPkg::opLoad, rvIsaPkg::opStore: begin
               known       = f3 == 3'd2; // word access only
               dataPending = known;
               pendWe      = op == rvIsaPkg::opStore;
               pendRd      = rd;
               pendData    = refRegs[ins[24:20]];
               pendAddr    = pendWe ? a + {{20{ins[31]}}, ins[31:25], ins[11:7]} : a + b;
            end
            default: known = 1'b0;
         endcase
         if (!known) begin
            refHalted = 1'b1;
         end else if (op != rvIsaPkg::opLoad && op != rvIsaPkg::opStore && rd != 5'd0) begin
            refRegs[rd] = res;
         end
      end
   endfunction

   task automatic stopRun();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic checkAddr(input memBusPkg::addrT got, input memBusPkg::addrT exp,
                            input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         stopRun();
      end
   endtask

   task automatic checkData(input memBusPkg::dataT got, input memBusPkg::dataT exp,
                            input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         stopRun();
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
         stopRun();
      end
   endtask

   // memory model with random latency per request
   always @(negedge clk) begin
      if (memRspValid) begin
         memRspValid = 1'b0;
         busy        = 1'b0;
      end else if (busy) begin
         waitCnt = waitCnt - 1;
         if (waitCnt == 0) begin
            memRspValid = 1'b1;
            if (memWe) begin
               mem[memAddr[7:0]] = memWData;
            end else begin
               memRData = mem[memAddr[7:0]];
            end
         end
      end else if (memReq) begin
         busy    = 1'b1;
         waitCnt = 1 + int'(nextRand() % 32'(maxLat));
      end
   end

   // every accepted request against the reference
   always @(posedge clk) begin
      logic            expWe;
      memBusPkg::addrT expAddr;
      memBusPkg::dataT expData;
      if (rstn && memReq && memRspValid) begin
         if (refHalted) begin
            $display("the core made a memory request while it should be halted");
            stopRun();
         end else begin
            refNext(expWe, expAddr, expData);
            checkFlag(memWe, expWe, "memWe");
            checkAddr(memAddr, expAddr, "memAddr");
            if (expWe) begin
               checkData(memWData, expData, "store data");
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > timeoutLimit) begin
         $display("timeout: the core did not finish within %0d cycles", timeoutLimit);
         stopRun();
      end
   end

   initial begin
      rvIsaPkg::wordT w;
      logic [4:0]     srcA;
      logic [4:0]     srcB;
      rstn        = 1'b0;
      launch      = 1'b0;
      memRspValid = 1'b0;
      memRData    = '0;
      for (int i = 0; i < 32; i++) begin
         refRegs[i] = '0;
      end
      // random operands in x1..x6
      for (int k = 1; k <= 6; k++) begin
         w = nextRand();
         if (k <= 2) begin
            w[31] = k == 1; // x1 negative, x2 positive
            w[11] = 1'b0;
            w[4]  = 1'b1;   // nonzero shift amount
         end
         prog.push_back(encU(w[31:12], 5'(k), rvIsaPkg::opLui));
         prog.push_back(encI(w[11:0], 5'(k), 3'd0, 5'(k), rvIsaPkg::opOpImm));
      end
      for (int k = 0; k < 10; k++) begin
         srcA = randomReg();
         srcB = randomReg();
         if (k == 5 || k == 6 || k == 9) begin
            srcA = 5'd1; // negative against positive
            srcB = 5'd2;
         end
         prog.push_back(encR(aluF7[k], srcB, srcA, aluF3[k], 5'd10));
         prog.push_back(encS(12'(128 + k), 5'd10, 5'd0));
      end
      for (int k = 0; k < 10; k++) begin
         if (k != 1) begin // no subi
            w    = nextRand();
            srcA = randomReg();
            if (k >= 7) begin
               w[11:5] = aluF7[k]; // shamt in w[4:0]
               w[4]    = 1'b1;
            end
            if (k == 5 || k == 6 || k == 9) begin
               srcA  = 5'd1;
               w[11] = 1'b0; // positive immediate
            end
            prog.push_back(encI(w[11:0], srcA, aluF3[k], 5'd11, rvIsaPkg::opOpImm));
            prog.push_back(encS(12'(138 + k), 5'd11, 5'd0));
         end
      end
      w = nextRand();
      prog.push_back(encU(w[31:12], 5'd12, rvIsaPkg::opAuipc));
      prog.push_back(encS(12'd148, 5'd12, 5'd0));
      prog.push_back(encU(w[19:0], 5'd0, rvIsaPkg::opLui)); // x0 must stay zero
      prog.push_back(encS(12'd149, 5'd0, 5'd0));
      prog.push_back(encI(12'd160, 5'd0, 3'd0, 5'd7, rvIsaPkg::opOpImm)); // base x7
      for (int k = 0; k < 4; k++) begin
         prog.push_back(encI(12'(40 + k), 5'd7, rvIsaPkg::f3Lw, 5'd13, rvIsaPkg::opLoad));
         prog.push_back(encS(12'(k), 5'd13, 5'd7));
      end
      prog.push_back(encS(12'd60, 5'd3, 5'd7));
      prog.push_back(encI(12'd60, 5'd7, rvIsaPkg::f3Lw, 5'd14, rvIsaPkg::opLoad));
      prog.push_back(encS(-12'sd10, 5'd14, 5'd7));
      prog.push_back({25'b0, rvIsaPkg::opHalt});
      prog.push_back(encR(7'h01, 5'd2, 5'd1, 3'd0, 5'd15)); // mul is not decoded

      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h9e37_79b9);
      end
      foreach (prog[i]) begin
         mem[i] = prog[i];
      end
      refMem       = mem;
      timeoutLimit = prog.size() * (4 + 2 * maxLat + 2) + 50;

      repeat (2) @(negedge clk);
      rstn = 1'b1;
      repeat (3) begin
         @(negedge clk);
         checkFlag(halt, 1'b1, "halt before launch");
         checkFlag(memReq, 1'b0, "memReq before launch");
      end
      launch = 1'b1;
      @(negedge clk);
      launch = 1'b0;
      while (!halt) @(negedge clk);
      checkFlag(halt, refHalted, "halt on 7f");
      repeat (6) begin
         @(negedge clk);
         checkFlag(memReq, 1'b0, "memReq while halted");
      end
      refHalted = 1'b0; // resume at the next word
      launch    = 1'b1;
      @(negedge clk);
      launch = 1'b0;
      while (!halt) @(negedge clk);
      checkFlag(halt, refHalted, "halt on invalid instruction");

      if (refHalted && !dataPending && refPc == 32'(prog.size())) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("the reference did not reach the end of the program");
         stopRun();
      end
   end

endmodule

`default_nettype wire

/* hw/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop #(
   parameter memBusPkg::addrT bootAddr = '0,
   parameter int              numRegs  = 32
) (
   input  logic             clk,
   input  logic             rstn,
   output logic             memReq,
   output memBusPkg::addrT  memAddr,
   output logic             memWe,
   output memBusPkg::dataT  memWData,
   input  logic             memRspValid,
   input  memBusPkg::dataT  memRData,
   input  logic             launch,
   output logic             halt
);

   rvIsaPkg::wordT   instr;
   memBusPkg::addrT  pc;
   rvIsaPkg::regIdxT rs1;
   rvIsaPkg::regIdxT rs2;
   rvIsaPkg::regIdxT rd;
   rvIsaPkg::wordT   imm;
   rvIsaPkg::aluOpT  aluOp;
   logic             useImm;
   logic             usePc;
   logic             regWrite;
   logic             isLoad;
   logic             isStore;
   logic             stop;
   rvIsaPkg::wordT   rs1Data;
   rvIsaPkg::wordT   rs2Data;
   rvIsaPkg::wordT   aluResult;
   logic             wEn;
   rvIsaPkg::regIdxT wAddr;
   rvIsaPkg::wordT   wData;

   coreSequencer #(.bootAddr(bootAddr)) u_seq (
      .clk         (clk),
      .rstn        (rstn),
      .launch      (launch),
      .memRspValid (memRspValid),
      .memRData    (memRData),
      .regWrite    (regWrite),
      .isLoad      (isLoad),
      .isStore     (isStore),
      .stop        (stop),
      .rd          (rd),
      .aluResult   (aluResult),
      .rs2Data     (rs2Data),
      .memReq      (memReq),
      .memAddr     (memAddr),
      .memWe       (memWe),
      .memWData    (memWData),
      .halt        (halt),
      .instr       (instr),
      .pc          (pc),
      .wEn         (wEn),
      .wAddr       (wAddr),
      .wData       (wData)
   );

   instDecoder u_dec (
      .instr    (instr),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .imm      (imm),
      .aluOp    (aluOp),
      .useImm   (useImm),
      .usePc    (usePc),
      .regWrite (regWrite),
      .isLoad   (isLoad),
      .isStore  (isStore),
      .stop     (stop)
   );

   alu u_alu (
      .aluOp   (aluOp),
      .useImm  (useImm),
      .usePc   (usePc),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .imm     (imm),
      .pc      (pc),
      .result  (aluResult)
   );

   regFile #(.numRegs(numRegs)) u_rf (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (rs1),
      .rs2     (rs2),
      .wEn     (wEn),
      .wAddr   (wAddr),
      .wData   (wData),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

endmodule

`default_nettype wire

/* hw/coreSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSequencer #(
   parameter memBusPkg::addrT bootAddr = '0
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             launch,
   input  logic             memRspValid,
   input  memBusPkg::dataT  memRData,
   input  logic             regWrite,
   input  logic             isLoad,
   input  logic             isStore,
   input  logic             stop,
   input  rvIsaPkg::regIdxT rd,
   input  rvIsaPkg::wordT   aluResult,
   input  rvIsaPkg::wordT   rs2Data,
   output logic             memReq,
   output memBusPkg::addrT  memAddr,
   output logic             memWe,
   output memBusPkg::dataT  memWData,
   output logic             halt,
   output rvIsaPkg::wordT   instr,
   output memBusPkg::addrT  pc,
   output logic             wEn,
   output rvIsaPkg::regIdxT wAddr,
   output rvIsaPkg::wordT   wData
);

   typedef enum logic [1:0] {
      stHalted,
      stFetch,
      stExecute,
      stData
   } stateT;

   stateT           state;
   memBusPkg::addrT pcNext; // next fetch address

   logic startFetch;
   logic startData;
   logic rspDone;
   logic fetchDone;

   // after a data response fetch sits one cycle with memReq low, then raises it
   assign startFetch = (state == stHalted && launch) ||
                       (state == stExecute && !stop && !isLoad && !isStore) ||
                       (state == stFetch && !memReq);
   assign startData  = state == stExecute && !stop && (isLoad || isStore);
   assign rspDone    = memReq && memRspValid;
   assign fetchDone  = state == stFetch && rspDone;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= stHalted;
         halt   <= 1'b1;
         memReq <= 1'b0;
         memWe  <= 1'b0;
         pcNext <= bootAddr;
      end else begin
         if (startFetch) begin
            memReq <= 1'b1;
            memWe  <= 1'b0;
            state  <= stFetch;
         end else if (startData) begin
            memReq <= 1'b1;
            memWe  <= isStore;
            state  <= stData;
         end else if (rspDone) begin
            memReq <= 1'b0;
            memWe  <= 1'b0;
            state  <= (state == stFetch) ? stExecute : stFetch;
         end else if (state == stExecute) begin
            // halt opcode or undecodable word
            halt  <= 1'b1;
            state <= stHalted;
         end

         if (state == stHalted && launch) begin
            halt <= 1'b0;
         end
         if (fetchDone) begin
            pcNext <= pcNext + 32'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (startFetch) begin
         memAddr <= pcNext;
      end else if (startData) begin
         memAddr  <= aluResult;  // rs1 + imm
         memWData <= rs2Data;
      end
      if (fetchDone) begin
         instr <= memRData;
         pc    <= memAddr;       // address of this instruction, for auipc
      end
   end

   // alu results in execute, load data at the response edge
   assign wEn   = (state == stExecute && regWrite && !stop) ||
                  (state == stData && rspDone && isLoad);
   assign wAddr = rd;        // instr holds until the next fetch
   assign wData = (state == stData) ? memRData : aluResult;

endmodule

`default_nettype wire

/* hw/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
   input  rvIsaPkg::wordT   instr,
   output rvIsaPkg::regIdxT rs1,
   output rvIsaPkg::regIdxT rs2,
   output rvIsaPkg::regIdxT rd,
   output rvIsaPkg::wordT   imm,
   output rvIsaPkg::aluOpT  aluOp,
   output logic             useImm,
   output logic             usePc,
   output logic             regWrite,
   output logic             isLoad,
   output logic             isStore,
   output logic             stop
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign rd  = instr[11:7];

   always_comb begin
      imm      = {{20{instr[31]}}, instr[31:20]}; // I format
      aluOp    = rvIsaPkg::aluAdd;
      useImm   = 1'b0;
      usePc    = 1'b0;
      regWrite = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      stop     = 1'b0;

      case (opcode)
         rvIsaPkg::opOp, rvIsaPkg::opOpImm: begin
            regWrite = 1'b1;
            useImm   = opcode == rvIsaPkg::opOpImm;
            case (funct3)
               rvIsaPkg::f3AddSub: begin
                  if (!useImm && funct7 == rvIsaPkg::f7Alt) begin
                     aluOp = rvIsaPkg::aluSub;
                  end else if (!useImm && funct7 != rvIsaPkg::f7Base) begin
                     stop = 1'b1;
                  end
               end
               rvIsaPkg::f3Sll: begin
                  aluOp = rvIsaPkg::aluSll;
                  stop  = funct7 != rvIsaPkg::f7Base;
               end
               rvIsaPkg::f3Sr: begin
                  // srai carries f7Alt in its immediate, shamt is the low bits
                  aluOp = (funct7 == rvIsaPkg::f7Alt) ? rvIsaPkg::aluSra : rvIsaPkg::aluSrl;
                  stop  = funct7 != rvIsaPkg::f7Base && funct7 != rvIsaPkg::f7Alt;
               end
               default: begin
                  case (funct3)
                     rvIsaPkg::f3Slt:  aluOp = rvIsaPkg::aluSlt;
                     rvIsaPkg::f3Sltu: aluOp = rvIsaPkg::aluSltu;
                     rvIsaPkg::f3Xor:  aluOp = rvIsaPkg::aluXor;
                     rvIsaPkg::f3Or:   aluOp = rvIsaPkg::aluOr;
                     default:          aluOp = rvIsaPkg::aluAnd;
                  endcase
                  stop = !useImm && funct7 != rvIsaPkg::f7Base;
               end
            endcase
         end
         rvIsaPkg::opLui, rvIsaPkg::opAuipc: begin
            imm      = {instr[31:12], 12'b0};
            useImm   = 1'b1;
            usePc    = opcode == rvIsaPkg::opAuipc;
            aluOp    = usePc ? rvIsaPkg::aluAdd : rvIsaPkg::aluPassB;
            regWrite = 1'b1;
         end
         rvIsaPkg::opLoad: begin
            useImm = 1'b1;
            isLoad = funct3 == rvIsaPkg::f3Lw;
            stop   = !isLoad;
         end
         rvIsaPkg::opStore: begin
            imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            useImm  = 1'b1;
            isStore = funct3 == rvIsaPkg::f3Sw;
            stop    = !isStore;
         end
         default: stop = 1'b1; // includes opHalt
      endcase

      if (stop) begin
         regWrite = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile #(
   parameter int numRegs = 32
) (
   input  logic             clk,
   input  logic             rstn,
   input  rvIsaPkg::regIdxT rs1,
   input  rvIsaPkg::regIdxT rs2,
   input  logic             wEn,
   input  rvIsaPkg::regIdxT wAddr,
   input  rvIsaPkg::wordT   wData,
   output rvIsaPkg::wordT   rs1Data,
   output rvIsaPkg::wordT   rs2Data
);

   localparam int idxW = $clog2(numRegs);

   rvIsaPkg::wordT regs [numRegs];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && wAddr != '0 && wAddr < numRegs) begin
         regs[wAddr[idxW-1:0]] <= wData; // x0 never written
      end
   end

   // indices past numRegs read as zero
   assign rs1Data = (rs1 < numRegs) ? regs[rs1[idxW-1:0]] : '0;
   assign rs2Data = (rs2 < numRegs) ? regs[rs2[idxW-1:0]] : '0;

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  rvIsaPkg::aluOpT aluOp,
   input  logic            useImm,
   input  logic            usePc,
   input  rvIsaPkg::wordT  rs1Data,
   input  rvIsaPkg::wordT  rs2Data,
   input  rvIsaPkg::wordT  imm,
   input  memBusPkg::addrT pc,
   output rvIsaPkg::wordT  result
);

   rvIsaPkg::wordT opA;
   rvIsaPkg::wordT opB;
   logic [4:0]     shamt;

   assign opA   = usePc ? pc : rs1Data;  // auipc
   assign opB   = useImm ? imm : rs2Data;
   assign shamt = opB[4:0];

   always_comb begin
      case (aluOp)
         rvIsaPkg::aluAdd:   result = opA + opB;
         rvIsaPkg::aluSub:   result = opA - opB;
         rvIsaPkg::aluXor:   result = opA ^ opB;
         rvIsaPkg::aluOr:    result = opA | opB;
         rvIsaPkg::aluAnd:   result = opA & opB;
         rvIsaPkg::aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
         rvIsaPkg::aluSltu:  result = {31'b0, opA < opB};
         rvIsaPkg::aluSll:   result = opA << shamt;
         rvIsaPkg::aluSrl:   result = opA >> shamt;
         rvIsaPkg::aluSra:   result = $signed(opA) >>> shamt;
         rvIsaPkg::aluPassB: result = opB;       // lui
         default:            result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/memBusPkg.sv */
`default_nettype none

package memBusPkg;

   // word index, not a byte address
   typedef logic [31:0] addrT;

   typedef rvIsaPkg::wordT dataT;

endpackage

`default_nettype wire

/* hw/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regIdxT;

   // major opcodes
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opAuipc = 7'b0010111;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opHalt  = 7'h7F;

   // funct3, alu forms
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll    = 3'b001;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Sltu   = 3'b011;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3Sr     = 3'b101;
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;
   localparam logic [2:0] f3Lw     = 3'b010; // word load only
   localparam logic [2:0] f3Sw     = 3'b010;

   localparam logic [6:0] f7Base = 7'b0000000;
   localparam logic [6:0] f7Alt  = 7'b0100000; // sub, sra

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSlt,
      aluSltu,
      aluSll,
      aluSrl,
      aluSra,
      aluPassB
   } aluOpT;

endpackage

`default_nettype wire
